/* project.f */
+incdir+common
common/macplus_pkg.sv
verilog/clk_enable_gen.sv
verilog/reset_sequencer.sv
loader/rom_loader.sv
verilog/sdram_mux.sv
verilog/drive_status.sv
verilog/macplus_io_top.sv
tests/tb_macplus_io.sv

/* tests/tb_macplus_io.sv */
// testbench for the glue layer top level
// directed tests for enables, reset, loader, sdram select and drive status
`timescale 1ns/1ps
`default_nettype none
`include "macplus_config.svh"

module tb_macplus_io;
  import macplus_pkg::*;

  localparam int TB_RESET_BITS = 4;
  localparam int TB_ACT_HOLD   = 64;
  // release bound of the sequencer, counted from the last reset source
  localparam int RESET_LIMIT    = 8 * (1 << TB_RESET_BITS) + 16;
  // the tests take well under two thousand cycles, this leaves a wide margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic        clk_sys;
  logic        RESET;
  logic        pll_locked;
  host_ctrl_t  ctrl;
  logic        user_button;
  logic        cpu_reset_out_n;
  logic        ioctl_wr;
  logic [24:0] ioctl_addr;
  logic [7:0]  ioctl_data;
  dl_index_e   dl_index;
  logic        dl_active;
  logic        ioctl_wait;
  logic        dio_slot;
  cpu_mem_t    cpu_mem;
  logic [1:0]  disk_ack;
  logic [15:0] sdram_data;
  sdram_req_t  sdram_req;
  logic [15:0] cpu_data;
  logic [1:0]  disk_eject;
  logic [1:0]  disk_motor;
  logic [1:0]  disk_act;
  logic        sd_ack;
  clk_en_t     clk_en;
  logic        sys_reset_n;
  logic [1:0]  ram_size;
  disk_state_t disk_state;
  logic        turbo;
  logic        led_user;

  string       cur_test;
  int          test_errs;
  int          total_errs;
  int          tests_run;
  int          tests_failed;
  int          cycle_count;
  logic        slot_run;
  logic [3:0]  slot_phase;
  disk_state_t expected_disk;

  macplus_io_top #(
    .RESET_BITS (TB_RESET_BITS),
    .ACT_HOLD   (TB_ACT_HOLD)
  ) u_dut (
    .clk_sys           (clk_sys),
    .RESET             (RESET),
    .pll_locked_i      (pll_locked),
    .ctrl_i            (ctrl),
    .user_button_i     (user_button),
    .cpu_reset_out_n_i (cpu_reset_out_n),
    .ioctl_wr_i        (ioctl_wr),
    .ioctl_addr_i      (ioctl_addr),
    .ioctl_data_i      (ioctl_data),
    .dl_index_i        (dl_index),
    .dl_active_i       (dl_active),
    .ioctl_wait_o      (ioctl_wait),
    .dio_slot_i        (dio_slot),
    .cpu_mem_i         (cpu_mem),
    .disk_ack_i        (disk_ack),
    .sdram_data_i      (sdram_data),
    .sdram_req_o       (sdram_req),
    .cpu_data_o        (cpu_data),
    .disk_eject_i      (disk_eject),
    .disk_motor_i      (disk_motor),
    .disk_act_i        (disk_act),
    .sd_ack_i          (sd_ack),
    .clk_en_o          (clk_en),
    .sys_reset_n_o     (sys_reset_n),
    .ram_size_o        (ram_size),
    .disk_state_o      (disk_state),
    .turbo_o           (turbo),
    .led_user_o        (led_user)
  );

  initial begin
    clk_sys = 1'b0;
    forever #2 clk_sys = ~clk_sys;
  end

  always @(posedge clk_sys) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles, a test never finished", cycle_count);
      $display("Verification failed");
      $finish;
    end
  end

  // ========================================
  // helpers
  // ========================================
  // dio slot is high for the last 4 cycles of every 16
  task slot_step;
    slot_phase = slot_phase + 4'd1;
    dio_slot   = (slot_phase >= 4'd12);
  endtask

  always @(negedge clk_sys) begin
    if (slot_run) begin
      slot_step;
    end
  end

  task set_slots(input logic on);
    @(negedge clk_sys);
    slot_run = on;
    if (!on) begin
      dio_slot   = 1'b0;
      slot_phase = 4'd0;
    end
  endtask

  // outputs are read one ns after the drive edge
  task sample_cycle;
    @(negedge clk_sys);
    #1;
  endtask

  task compare_value(input string what, input logic [63:0] expected,
                     input logic [63:0] actual);
    assert (expected === actual)
      else begin
        $display("Fail %s %s: expected %h actual %h", cur_test, what, expected, actual);
        test_errs++;
      end
  endtask

  task require(input logic cond, input string msg);
    assert (cond === 1'b1)
      else begin
        $display("%s: %s", cur_test, msg);
        test_errs++;
      end
  endtask

  task begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task end_test;
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("%s ok", cur_test);
    end else begin
      tests_failed++;
      $display("%s failed with %0d errors", cur_test, test_errs);
    end
  endtask

  // wait until the sequencer lets the system run, at most the release bound
  task wait_release(input string msg);
    int n;
    n = 0;
    while (!sys_reset_n && n < RESET_LIMIT) begin
      sample_cycle;
      n++;
    end
    require(sys_reset_n, msg);
  endtask

  function automatic logic [20:0] image_base(input dl_index_e idx);
    case (idx)
      dl_disk_int: return `CFG_DSK1_BASE;
      dl_disk_ext: return `CFG_DSK2_BASE;
      default:     return 21'd0;
    endcase
  endfunction

  // ========================================
  // tests
  // ========================================
  task test_clk_enables;
    clk_en_t hist [64];
    clk_en_t exp;
    int      k;
    int      first_cep;
    int      first_pix;
    begin_test("test_clk_enables");
    first_cep = -1;
    first_pix = -1;
    for (k = 0; k < 64; k++) begin
      sample_cycle;
      hist[k] = clk_en;
      if (first_cep < 0 && k < 8 && clk_en.cep) first_cep = k;
      if (first_pix < 0 && k < 4 && clk_en.cepix) first_pix = k;
    end
    require(first_cep >= 0 && first_pix >= 0, "no cep or cepix pulse at the start");
    if (first_cep >= 0 && first_pix >= 0) begin
      for (k = 0; k < 64; k++) begin
        exp.cep   = ((k - first_cep + 64) % 8 == 0);
        exp.cen   = ((k - first_cep + 64) % 8 == 4);
        exp.cel   = ((k - first_cep + 64) % 8 == 7);
        exp.cepix = ((k - first_pix + 64) % 4 == 0);
        compare_value("clock enables", exp, hist[k]);
      end
    end
    end_test;
  endtask

  task test_reset;
    logic       high_seen;
    logic [1:0] exp_size;
    begin_test("test_reset");
    high_seen = 1'b0;
    wait_release("sys_reset_n_o was not released after the power on reset");
    // each source is held longer than the release bound
    @(negedge clk_sys);
    pll_locked   = 1'b0;
    ctrl.mem_sel = 2'd3;
    repeat (RESET_LIMIT) begin
      sample_cycle;
      if (sys_reset_n) high_seen = 1'b1;
    end
    @(negedge clk_sys);
    pll_locked     = 1'b1;
    ctrl.osd_reset = 1'b1;
    repeat (RESET_LIMIT) begin
      sample_cycle;
      if (sys_reset_n) high_seen = 1'b1;
    end
    compare_value("sys_reset_n while held", 0, high_seen);
    @(negedge clk_sys);
    ctrl.osd_reset = 1'b0;
    wait_release("sys_reset_n_o was not released within the reset bound");
    exp_size = ctrl.mem_sel + 2'd1;
    compare_value("ram size", exp_size, ram_size);
    end_test;
  endtask

  // one word as two host bytes, then watch the paced sdram write
  task send_word(input logic [24:0] byte_addr, input dl_index_e idx);
    logic [7:0] hi;
    logic [7:0] lo;
    sdram_req_t exp;
    int         waited;
    int         writes;
    logic       we_prev;
    hi       = 8'($urandom());
    lo       = 8'($urandom());
    exp.addr = {`CFG_DL_REGION, image_base(idx) + byte_addr[21:1]};
    exp.din  = {hi, lo};
    exp.ds   = 2'b11;
    exp.we   = 1'b1;
    exp.oe   = 1'b0;
    @(negedge clk_sys);
    dl_index   = idx;
    ioctl_wr   = 1'b1;
    ioctl_addr = byte_addr;
    ioctl_data = hi;
    @(negedge clk_sys);
    ioctl_addr = byte_addr + 25'd1;
    ioctl_data = lo;
    @(negedge clk_sys);
    ioctl_wr = 1'b0;
    waited = 0;
    while (!ioctl_wait && waited < 8) begin
      sample_cycle;
      waited++;
    end
    require(ioctl_wait, "ioctl_wait_o never rose after a completed word");
    writes  = 0;
    we_prev = 1'b0;
    while (ioctl_wait && waited < 64) begin
      sample_cycle;
      if (sdram_req.we && !we_prev) begin
        writes++;
        compare_value("download request", exp, sdram_req);
        compare_value("cpu data during download", 16'hffff, cpu_data);
      end
      we_prev = sdram_req.we;
      waited++;
    end
    require(!ioctl_wait, "ioctl_wait_o stuck high after the write");
    compare_value("writes per word", 1, writes);
  endtask

  task test_rom_download;
    int i;
    begin_test("test_rom_download");
    set_slots(1'b1);
    @(negedge clk_sys);
    dl_active = 1'b1;
    for (i = 0; i < 4; i++) begin
      send_word(25'(2 * i), dl_os_rom);
    end
    for (i = 0; i < 4; i++) begin
      send_word(25'(16'h0200 + 2 * i), dl_disk_int);
    end
    @(negedge clk_sys);
    dl_active = 1'b0;
    set_slots(1'b0);
    end_test;
  endtask

  task finish_image(input dl_index_e idx, input int words);
    int i;
    i = (idx == dl_disk_ext) ? 1 : 0;
    @(negedge clk_sys);
    dl_index   = idx;
    ioctl_addr = 25'(words * 2);
    dl_active  = 1'b1;
    repeat (2) @(negedge clk_sys);
    dl_active = 1'b0;
    repeat (2) sample_cycle;
    expected_disk.inserted[i]  = (words == `CFG_DSK_DS_WORDS) ||
                                 (words == `CFG_DSK_SS_WORDS);
    expected_disk.dbl_sided[i] = (words == `CFG_DSK_DS_WORDS);
    compare_value("disk state", expected_disk, disk_state);
  endtask

  task test_disk_detect;
    begin_test("test_disk_detect");
    expected_disk = '0;
    finish_image(dl_disk_int, 409600);
    finish_image(dl_disk_ext, 204800);
    finish_image(dl_disk_int, 1000);
    @(negedge clk_sys);
    disk_eject = 2'b11;
    @(negedge clk_sys);
    disk_eject = 2'b00;
    sample_cycle;
    compare_value("disk state after eject", 0, disk_state);
    end_test;
  endtask

  task test_cpu_path;
    sdram_req_t  exp;
    logic [15:0] exp_data;
    int          k;
    begin_test("test_cpu_path");
    for (k = 0; k < 5; k++) begin
      @(negedge clk_sys);
      cpu_mem.addr     = 22'($urandom());
      cpu_mem.wdata    = 16'($urandom());
      cpu_mem.uds_n    = 1'($urandom());
      cpu_mem.lds_n    = 1'($urandom());
      // ram read, rom read, ram write, then two disk reads
      cpu_mem.rom_oe_n = (k != 1);
      cpu_mem.ram_oe_n = (k == 1 || k == 2);
      cpu_mem.ram_we_n = (k != 2);
      cpu_mem.addr[0]  = (k == 4);
      sdram_data       = 16'($urandom());
      disk_ack         = (k >= 3) ? 2'b01 : 2'b00;
      #1;
      // only the rom read lands in the rom region, only the write drives we
      exp.addr = {3'b000, (k == 1), cpu_mem.addr[21:1]};
      exp.din  = cpu_mem.wdata;
      exp.ds   = ~{cpu_mem.uds_n, cpu_mem.lds_n};
      exp.we   = (k == 2);
      exp.oe   = (k != 2);
      compare_value("cpu request", exp, sdram_req);
      if (k < 3) begin
        exp_data = sdram_data;
      end else if (cpu_mem.addr[0]) begin
        exp_data = {sdram_data[7:0], sdram_data[7:0]};
      end else begin
        exp_data = {sdram_data[15:8], sdram_data[15:8]};
      end
      compare_value("cpu data", exp_data, cpu_data);
    end
    @(negedge clk_sys);
    cpu_mem  = '{addr: 22'd0, wdata: 16'd0, default: 1'b1};
    disk_ack = 2'b00;
    end_test;
  endtask

  task pulse_sd_ack;
    @(negedge clk_sys);
    sd_ack = 1'b1;
    @(negedge clk_sys);
    sd_ack = 1'b0;
  endtask

  task test_turbo_led;
    logic seen;
    int   n;
    begin_test("test_turbo_led");
    set_slots(1'b1);
    ctrl.turbo = 1'b1;
    seen = 1'b0;
    for (n = 0; n < 19; n++) begin
      pulse_sd_ack;
      if (turbo) seen = 1'b1;
    end
    repeat (40) begin
      sample_cycle;
      if (turbo) seen = 1'b1;
    end
    compare_value("turbo before the last ack", 0, seen);
    pulse_sd_ack;
    n = 0;
    while (!turbo && n < 40) begin
      sample_cycle;
      n++;
    end
    require(turbo, "turbo_o did not follow the turbo request after the last ack");
    @(negedge clk_sys);
    ctrl.turbo = 1'b0;
    n = 0;
    while (turbo && n < 40) begin
      sample_cycle;
      n++;
    end
    require(!turbo, "turbo_o did not drop with the turbo request");
    set_slots(1'b0);
    dl_index  = dl_os_rom;
    dl_active = 1'b1;
    #1;
    compare_value("led during download", 1, led_user);
    @(negedge clk_sys);
    dl_active = 1'b0;
    #1;
    compare_value("led after download", 0, led_user);
    // one activity pulse keeps the led lit for about the hold time
    @(negedge clk_sys);
    disk_act = 2'b01;
    @(negedge clk_sys);
    disk_act = 2'b00;
    sample_cycle;
    compare_value("led after disk activity", 1, led_user);
    n = 0;
    while (led_user && n < 2 * TB_ACT_HOLD) begin
      sample_cycle;
      n++;
    end
    require(n > TB_ACT_HOLD - 4 && n < TB_ACT_HOLD + 4,
            "led_user_o did not hold the disk activity for the hold time");
    end_test;
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    void'($urandom(32'he4da352d));
    cycle_count     = 0;
    total_errs      = 0;
    tests_run       = 0;
    tests_failed    = 0;
    slot_run        = 1'b0;
    slot_phase      = 4'd0;
    RESET           = 1'b1;
    pll_locked      = 1'b1;
    ctrl            = '0;
    user_button     = 1'b0;
    cpu_reset_out_n = 1'b1;
    ioctl_wr        = 1'b0;
    ioctl_addr      = '0;
    ioctl_data      = '0;
    dl_index        = dl_os_rom;
    dl_active       = 1'b0;
    dio_slot        = 1'b0;
    cpu_mem         = '{addr: 22'd0, wdata: 16'd0, default: 1'b1};
    disk_ack        = 2'b00;
    sdram_data      = '0;
    disk_eject      = 2'b00;
    disk_motor      = 2'b00;
    disk_act        = 2'b00;
    sd_ack          = 1'b0;
    expected_disk   = '0;
    repeat (3) @(posedge clk_sys);
    @(negedge clk_sys);
    RESET = 1'b0;

    test_clk_enables;
    test_reset;
    test_rom_download;
    test_disk_detect;
    test_cpu_path;
    test_turbo_led;

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/macplus_io_top.sv */
// glue layer top level
// clock enables, reset, image loader, sdram select and drive status
`timescale 1ns/1ps
`default_nettype none
`include "macplus_config.svh"

module macplus_io_top #(
  parameter int RESET_BITS = `CFG_RESET_BITS,
  parameter int ACT_HOLD   = `CFG_ACT_HOLD
) (
  input  wire                      clk_sys,
  input  wire                      RESET,
  input  wire                      pll_locked_i,
  input  macplus_pkg::host_ctrl_t  ctrl_i,
  input  wire                      user_button_i,
  input  wire                      cpu_reset_out_n_i,
  // host download
  input  wire                      ioctl_wr_i,
  input  wire [24:0]               ioctl_addr_i,
  input  wire [7:0]                ioctl_data_i,
  input  macplus_pkg::dl_index_e   dl_index_i,
  input  wire                      dl_active_i,
  output wire                      ioctl_wait_o,
  // bus control and memory side
  input  wire                      dio_slot_i,
  input  macplus_pkg::cpu_mem_t    cpu_mem_i,
  input  wire [1:0]                disk_ack_i,
  input  wire [15:0]               sdram_data_i,
  output macplus_pkg::sdram_req_t  sdram_req_o,
  output wire [15:0]               cpu_data_o,
  // floppy and block device
  input  wire [1:0]                disk_eject_i,
  input  wire [1:0]                disk_motor_i,
  input  wire [1:0]                disk_act_i,
  input  wire                      sd_ack_i,
  output macplus_pkg::clk_en_t     clk_en_o,
  output wire                      sys_reset_n_o,
  output wire [1:0]                ram_size_o,
  output macplus_pkg::disk_state_t disk_state_o,
  output wire                      turbo_o,
  output wire                      led_user_o
);
  import macplus_pkg::*;

  clk_en_t  clk_en;
  dl_word_t dl_word;
  logic     sys_reset_n;

  clk_enable_gen u_clk_en (
    .clk_sys  (clk_sys),
    .RESET    (RESET),
    .clk_en_o (clk_en)
  );

  reset_sequencer #(.RESET_BITS(RESET_BITS)) u_reset (
    .clk_sys           (clk_sys),
    .RESET             (RESET),
    .pll_locked_i      (pll_locked_i),
    .ctrl_i            (ctrl_i),
    .user_button_i     (user_button_i),
    .cpu_reset_out_n_i (cpu_reset_out_n_i),
    .clk_en_i          (clk_en),
    .sys_reset_n_o     (sys_reset_n),
    .ram_size_o        (ram_size_o)
  );

  rom_loader u_loader (
    .clk_sys      (clk_sys),
    .RESET        (RESET),
    .ioctl_wr_i   (ioctl_wr_i),
    .ioctl_addr_i (ioctl_addr_i),
    .ioctl_data_i (ioctl_data_i),
    .dl_index_i   (dl_index_i),
    .dio_slot_i   (dio_slot_i),
    .dl_word_o    (dl_word),
    .ioctl_wait_o (ioctl_wait_o)
  );

  sdram_mux u_mux (
    .dl_active_i  (dl_active_i),
    .dio_slot_i   (dio_slot_i),
    .dl_word_i    (dl_word),
    .cpu_mem_i    (cpu_mem_i),
    .disk_ack_i   (disk_ack_i),
    .sdram_data_i (sdram_data_i),
    .sdram_req_o  (sdram_req_o),
    .cpu_data_o   (cpu_data_o)
  );

  // final host address in words gives the image size
  drive_status #(.ACT_HOLD(ACT_HOLD)) u_drive (
    .clk_sys       (clk_sys),
    .RESET         (RESET),
    .sys_reset_n_i (sys_reset_n),
    .dl_active_i   (dl_active_i),
    .dl_index_i    (dl_index_i),
    .dl_words_i    ({1'b0, ioctl_addr_i[24:1]}),
    .disk_eject_i  (disk_eject_i),
    .disk_motor_i  (disk_motor_i),
    .disk_act_i    (disk_act_i),
    .sd_ack_i      (sd_ack_i),
    .dio_slot_i    (dio_slot_i),
    .turbo_req_i   (ctrl_i.turbo),
    .disk_state_o  (disk_state_o),
    .turbo_o       (turbo_o),
    .led_user_o    (led_user_o)
  );

  assign clk_en_o      = clk_en;
  assign sys_reset_n_o = sys_reset_n;

endmodule

`default_nettype wire

/* verilog/drive_status.sv */
// floppy, turbo and activity status
// latches image presence at download end, delays turbo and drives the user led
`timescale 1ns/1ps
`default_nettype none
`include "macplus_config.svh"

module drive_status #(
  parameter int ACT_HOLD = `CFG_ACT_HOLD
) (
  input  wire                      clk_sys,
  input  wire                      RESET,
  input  wire                      sys_reset_n_i,
  input  wire                      dl_active_i,
  input  macplus_pkg::dl_index_e   dl_index_i,
  input  wire [24:0]               dl_words_i,
  input  wire [1:0]                disk_eject_i,
  input  wire [1:0]                disk_motor_i,
  input  wire [1:0]                disk_act_i,
  input  wire                      sd_ack_i,
  input  wire                      dio_slot_i,
  input  wire                      turbo_req_i,
  output macplus_pkg::disk_state_t disk_state_o,
  output logic                     turbo_o,
  output logic                     led_user_o
);
  import macplus_pkg::*;

  localparam int ACK_W  = $clog2(`CFG_TURBO_ACKS + 1);
  localparam int HOLD_W = $clog2(ACT_HOLD + 1);

  logic              dl_active_q;
  logic [1:0]        dl_end;
  logic              is_ds;
  logic              is_ss;
  disk_state_t       disk_q;
  logic              sd_ack_q;
  logic [ACK_W-1:0]  ack_cnt;
  logic [HOLD_W-1:0] act_timer;
  logic              act_hold;

  // ========================================
  // image detection
  // ========================================
  // image size tells the sides, any other size is no disk
  assign is_ds = (dl_words_i == 25'(`CFG_DSK_DS_WORDS));
  assign is_ss = (dl_words_i == 25'(`CFG_DSK_SS_WORDS));

  assign dl_end[0] = dl_active_q && !dl_active_i && (dl_index_i == dl_disk_int);
  assign dl_end[1] = dl_active_q && !dl_active_i && (dl_index_i == dl_disk_ext);

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      dl_active_q <= 1'b0;
      disk_q      <= '0;
    end else begin
      dl_active_q <= dl_active_i;
      for (int i = 0; i < 2; i++) begin
        if (dl_end[i]) begin
          disk_q.inserted[i]  <= is_ds || is_ss;
          disk_q.dbl_sided[i] <= is_ds;
        end
        // eject from the os wins over a finishing download
        if (disk_eject_i[i]) begin
          disk_q.inserted[i]  <= 1'b0;
          disk_q.dbl_sided[i] <= 1'b0;
        end
      end
    end
  end

  assign disk_state_o = disk_q;

  // ========================================
  // turbo delay
  // ========================================
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      sd_ack_q <= 1'b0;
      ack_cnt  <= ACK_W'(`CFG_TURBO_ACKS);
      turbo_o  <= 1'b0;
    end else begin
      sd_ack_q <= sd_ack_i;
      if (sd_ack_q && !sd_ack_i && (ack_cnt != '0)) begin
        ack_cnt <= ack_cnt - 1'b1;
      end
      // floppy access means the scsi boot is over
      if (|disk_motor_i) begin
        ack_cnt <= '0;
      end
      if ((ack_cnt == '0) && dio_slot_i) begin
        turbo_o <= turbo_req_i;
      end
      if (!sys_reset_n_i) begin
        turbo_o <= 1'b0;
        ack_cnt <= ACK_W'(`CFG_TURBO_ACKS);
      end
    end
  end

  // activity stretcher for the led
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      act_timer <= '0;
      act_hold  <= 1'b0;
    end else begin
      act_hold <= (act_timer != '0);
      if (|disk_act_i) begin
        act_timer <= HOLD_W'(ACT_HOLD);
      end else if (act_timer != '0) begin
        act_timer <= act_timer - 1'b1;
      end
    end
  end

  assign led_user_o = dl_active_i || (act_hold ^ |disk_motor_i);

endmodule

`default_nettype wire

/* verilog/sdram_mux.sv */
// sdram port select between download and cpu memory side
// disk image reads get the addressed byte on both halves
`timescale 1ns/1ps
`default_nettype none
`include "macplus_config.svh"

module sdram_mux (
  input  wire                     dl_active_i,
  input  wire                     dio_slot_i,
  input  macplus_pkg::dl_word_t   dl_word_i,
  input  macplus_pkg::cpu_mem_t   cpu_mem_i,
  input  wire [1:0]               disk_ack_i,
  input  wire [15:0]              sdram_data_i,
  output macplus_pkg::sdram_req_t sdram_req_o,
  output logic [15:0]             cpu_data_o
);
  import macplus_pkg::*;

  logic        download_cycle;
  logic [15:0] disk_byte_data;
  sdram_req_t  cpu_req;
  sdram_req_t  dl_req;

  assign download_cycle = dl_active_i && dio_slot_i;

  // rom and ram share the low space, the rom flag picks the region
  assign cpu_req.addr = {3'b000, !cpu_mem_i.rom_oe_n, cpu_mem_i.addr[21:1]};
  assign cpu_req.din  = cpu_mem_i.wdata;
  assign cpu_req.ds   = {!cpu_mem_i.uds_n, !cpu_mem_i.lds_n};
  assign cpu_req.we   = !cpu_mem_i.ram_we_n;
  assign cpu_req.oe   = !cpu_mem_i.ram_oe_n || !cpu_mem_i.rom_oe_n;

  assign dl_req.addr = {`CFG_DL_REGION, dl_word_i.addr};
  assign dl_req.din  = dl_word_i.data;
  assign dl_req.ds   = 2'b11;
  assign dl_req.we   = dl_word_i.wr;
  assign dl_req.oe   = 1'b0;

  assign sdram_req_o = download_cycle ? dl_req : cpu_req;

  // floppy controller reads bytes, odd address takes the low byte
  assign disk_byte_data = cpu_mem_i.addr[0] ? {2{sdram_data_i[7:0]}} :
                                              {2{sdram_data_i[15:8]}};

  always_comb begin
    if (download_cycle) begin
      cpu_data_o = 16'hffff;
    end else if (|disk_ack_i) begin
      cpu_data_o = disk_byte_data;
    end else begin
      cpu_data_o = sdram_data_i;
    end
  end

  a_we_oe_exclusive: assert final (!(sdram_req_o.we && sdram_req_o.oe))
    else $error("sdram write and output enable both active");

endmodule

`default_nettype wire

/* loader/rom_loader.sv */
// rom and disk image loader
// pairs host bytes into words, maps them into sdram and paces one write per slot
`timescale 1ns/1ps
`default_nettype none
`include "macplus_config.svh"

module rom_loader (
  input  wire                    clk_sys,
  input  wire                    RESET,
  input  wire                    ioctl_wr_i,
  input  wire [24:0]             ioctl_addr_i,
  input  wire [7:0]              ioctl_data_i,
  input  macplus_pkg::dl_index_e dl_index_i,
  input  wire                    dio_slot_i,
  output macplus_pkg::dl_word_t  dl_word_o,
  output logic                   ioctl_wait_o
);
  import macplus_pkg::*;

  load_state_e state;
  logic [7:0]  hi_byte;
  logic [15:0] word_data;
  logic [20:0] word_addr;
  logic [20:0] mapped_addr;
  logic        word_done;
  logic        dl_wr;
  logic        slot_q;

  // ========================================
  // byte pairing and address map
  // ========================================
  always_comb begin
    case (dl_index_i)
      dl_disk_int: mapped_addr = `CFG_DSK1_BASE + ioctl_addr_i[21:1];
      dl_disk_ext: mapped_addr = `CFG_DSK2_BASE + ioctl_addr_i[21:1];
      default:     mapped_addr = ioctl_addr_i[21:1];
    endcase
  end

  // even address holds the high byte
  always_ff @(posedge clk_sys) begin
    if (ioctl_wr_i && !ioctl_addr_i[0]) begin
      hi_byte <= ioctl_data_i;
    end
    if (ioctl_wr_i && ioctl_addr_i[0]) begin
      word_data <= {hi_byte, ioctl_data_i};
      word_addr <= mapped_addr;
    end
  end

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      word_done <= 1'b0;
    end else begin
      word_done <= ioctl_wr_i && ioctl_addr_i[0];
    end
  end

  // ========================================
  // slot paced write
  // ========================================
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      state        <= load_idle;
      ioctl_wait_o <= 1'b0;
      dl_wr        <= 1'b0;
      slot_q       <= 1'b0;
    end else begin
      slot_q <= dio_slot_i;
      case (state)
        load_idle: begin
          if (word_done) begin
            state        <= load_pending;
            ioctl_wait_o <= 1'b1;
          end
        end
        load_pending: begin
          // arm the strobe outside the slot so the next slot sees it whole
          if (!dio_slot_i) begin
            dl_wr <= 1'b1;
            state <= load_writing;
          end
        end
        load_writing: begin
          if (slot_q && !dio_slot_i) begin
            dl_wr        <= 1'b0;
            ioctl_wait_o <= 1'b0;
            state        <= load_idle;
          end
        end
        default: state <= load_idle;
      endcase
    end
  end

  assign dl_word_o = '{addr: word_addr, data: word_data, wr: dl_wr};

  a_host_respects_wait: assert property (@(posedge clk_sys) disable iff (RESET)
    ioctl_wait_o |-> !ioctl_wr_i)
    else $error("host wrote a byte while the loader was waiting");

endmodule

`default_nettype wire

/* verilog/reset_sequencer.sv */
// system reset sequencer
// merges all reset sources, stretches the reset and latches the ram size
`timescale 1ns/1ps
`default_nettype none
`include "macplus_config.svh"

module reset_sequencer #(
  parameter int RESET_BITS = `CFG_RESET_BITS
) (
  input  wire                     clk_sys,
  input  wire                     RESET,
  input  wire                     pll_locked_i,
  input  macplus_pkg::host_ctrl_t ctrl_i,
  input  wire                     user_button_i,
  input  wire                     cpu_reset_out_n_i,
  input  macplus_pkg::clk_en_t    clk_en_i,
  output logic                    sys_reset_n_o,
  output logic [1:0]              ram_size_o
);
  import macplus_pkg::*;

  logic [4:0]            reset_pipe;
  logic                  sync_reset;
  logic                  any_reset;
  logic [RESET_BITS-1:0] rst_cnt;

  // the async reset leaves through a short shift pipe
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      reset_pipe <= '1;
    end else begin
      reset_pipe <= {reset_pipe[3:0], 1'b0};
    end
  end

  assign sync_reset = reset_pipe[4];

  assign any_reset = !pll_locked_i || ctrl_i.osd_reset || ctrl_i.menu_reset ||
                     user_button_i || sync_reset || !cpu_reset_out_n_i;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      rst_cnt       <= '1;
      sys_reset_n_o <= 1'b0;
      ram_size_o    <= 2'd3;
    end else if (any_reset) begin
      rst_cnt       <= '1;
      sys_reset_n_o <= 1'b0;
    end else if (|rst_cnt) begin
      if (clk_en_i.cen) begin
        rst_cnt <= rst_cnt - 1'b1;
      end
      // memory option only takes effect across a reset
      ram_size_o <= ctrl_i.mem_sel + 2'd1;
    end else begin
      sys_reset_n_o <= 1'b1;
    end
  end

  a_pll_holds_reset: assert property (@(posedge clk_sys) disable iff (RESET)
    !$past(pll_locked_i) |-> !sys_reset_n_o)
    else $error("system reset released with pll unlocked");

endmodule

`default_nettype wire

/* verilog/clk_enable_gen.sv */
// clock enable divider
// cpu phase strobes every 8 cycles and pixel strobe every 4
`timescale 1ns/1ps
`default_nettype none

module clk_enable_gen (
  input  wire                  clk_sys,
  input  wire                  RESET,
  output macplus_pkg::clk_en_t clk_en_o
);
  import macplus_pkg::*;

  logic [2:0] div;
  clk_en_t    en_q;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      div  <= 3'd0;
      en_q <= '0;
    end else begin
      div       <= div + 3'd1;
      // cen trails cep by half a cpu cycle, cel closes the cycle
      en_q.cep   <= (div == 3'd0);
      en_q.cen   <= (div == 3'd4);
      en_q.cel   <= (div == 3'd7);
      en_q.cepix <= (div[1:0] == 2'd0);
    end
  end

  assign clk_en_o = en_q;

endmodule

`default_nettype wire

/* common/macplus_pkg.sv */
// shared types for the compact computer glue layer
// download kinds, loader states and the packed buses between blocks
`default_nettype none

package macplus_pkg;

  // kind of image the host is downloading
  typedef enum logic [1:0] {
    dl_os_rom   = 2'd0,
    dl_disk_int = 2'd1,
    dl_disk_ext = 2'd2
  } dl_index_e;

  // loader write pacing
  typedef enum logic [1:0] {
    load_idle,
    load_pending,
    load_writing
  } load_state_e;

  typedef struct packed {
    logic cep;
    logic cen;
    logic cel;
    logic cepix;
  } clk_en_t;

  // cpu side memory request, strobes and enables active low
  typedef struct packed {
    logic [21:0] addr;
    logic [15:0] wdata;
    logic        uds_n;
    logic        lds_n;
    logic        rom_oe_n;
    logic        ram_oe_n;
    logic        ram_we_n;
  } cpu_mem_t;

  typedef struct packed {
    logic [24:0] addr;
    logic [15:0] din;
    logic [1:0]  ds;
    logic        we;
    logic        oe;
  } sdram_req_t;

  typedef struct packed {
    logic [20:0] addr;
    logic [15:0] data;
    logic        wr;
  } dl_word_t;

  typedef struct packed {
    logic       osd_reset;
    logic       menu_reset;
    logic       turbo;
    logic [1:0] mem_sel;
  } host_ctrl_t;

  // index 0 is the internal drive, index 1 the external one
  typedef struct packed {
    logic [1:0] inserted;
    logic [1:0] dbl_sided;
  } disk_state_t;

endpackage

`default_nettype wire

/* common/macplus_config.svh */
// default sizes and offsets for the glue layer
// counter widths, hold times, floppy image sizes and sdram regions
`ifndef MACPLUS_CONFIG_SVH
`define MACPLUS_CONFIG_SVH

// reset stretch counter width
`define CFG_RESET_BITS 16

// activity led hold in clk_sys cycles
`define CFG_ACT_HOLD 1000000

// block device acks seen before turbo may be enabled
`define CFG_TURBO_ACKS 20

// ========================================
// floppy images, counted in words
// ========================================
`define CFG_DSK_DS_WORDS 409600
`define CFG_DSK_SS_WORDS 204800

// word offsets of the disk images behind the os rom
`define CFG_DSK1_BASE 21'h080000
`define CFG_DSK2_BASE 21'h100000

// ========================================
// sdram layout
// ========================================
// region prefix in front of the 21 bit download word address
`define CFG_DL_REGION 4'b0001

`endif
